// File: verilog/axi_xbar_pkg.sv
package axi_xbar_pkg;

    localparam int num_masters = 3;
    localparam int num_slaves  = 3;
    localparam int mtag_w      = 2;             // master index carried in the upper sid bits
    localparam int id_w        = 4;
    localparam int sid_w       = id_w + mtag_w;
    localparam int addr_w      = 32;
    localparam int data_w      = 32;
    localparam int len_w       = 8;
    localparam int sel_lsb     = 28;            // addr[29:28] selects the slave
    localparam int sidx_w      = $clog2(num_slaves);
    localparam int fifo_aw     = 1;             // two entries per fifo

    typedef logic [id_w-1:0]   id_t;
    typedef logic [sid_w-1:0]  sid_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [len_w-1:0]  len_t;
    typedef logic [1:0]        resp_t;
    typedef logic [mtag_w-1:0] mtag_t;
    typedef logic [sidx_w-1:0] sidx_t;

    localparam resp_t resp_okay = 2'b00;

    // master side read address
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        len_t       len;
        logic [2:0] size;
        logic [1:0] burst;
    } ar_req_t;

    // slave side read address, id widened by the master tag
    typedef struct packed {
        sid_t       sid;
        addr_t      addr;
        len_t       len;
        logic [2:0] size;
        logic [1:0] burst;
    } s_ar_req_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

    typedef struct packed {
        sid_t  sid;
        data_t data;
        resp_t resp;
        logic  last;
    } s_r_beat_t;

endpackage

// File: verilog/axi_fifo_sync.sv
`timescale 1ns/1ps

module axi_fifo_sync #(
    parameter int width = 8,
    parameter int aw    = 1        // depth is 2**aw
) (
    input  logic             axi_clk,
    input  logic             reset,
    input  logic             wr_valid,
    output logic             wr_ready,
    input  logic [width-1:0] wr_data,
    output logic             rd_valid,
    input  logic             rd_ready,
    output logic [width-1:0] rd_data
);

    localparam int depth = 1 << aw;

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;
    logic [aw:0]      count;       // msb set means full
    logic             push;
    logic             pop;

    // a full fifo still takes a word when the head leaves in the same cycle
    assign wr_ready = !count[aw] || rd_ready;
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or pass through
            endcase
        end
    end

    always_ff @(posedge axi_clk) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    // a refused write leaves only the pop to move the count
    assert property (@(posedge axi_clk) disable iff (reset)
        wr_valid && !wr_ready |=> count == $past(count) - $past(pop));

endmodule

// File: verilog/ar_arbiter.sv
`timescale 1ns/1ps

module ar_arbiter (
    input  logic                                 axi_clk,
    input  logic                                 reset,
    input  axi_xbar_pkg::ar_req_t                req [axi_xbar_pkg::num_masters],
    input  logic [axi_xbar_pkg::num_masters-1:0] req_valid,
    output logic [axi_xbar_pkg::num_masters-1:0] req_pop,
    output axi_xbar_pkg::s_ar_req_t              s_ar,
    output logic                                 s_arvalid,
    input  logic                                 s_arready
);
    import axi_xbar_pkg::*;

    mtag_t                  last_q;         // winner of the previous handshake
    logic                   locked_q;       // grant shown, slave not ready yet
    mtag_t                  locked_idx_q;
    mtag_t                  pick;
    logic                   pick_valid;
    mtag_t                  win;
    logic [num_masters-1:0] grant;
    logic                   s_hs;

    // first valid master after the last winner, nearest one assigned last
    always_comb begin
        pick       = last_q;
        pick_valid = 1'b0;
        for (int k = num_masters; k >= 1; k--) begin
            if (req_valid[(int'(last_q) + k) % num_masters]) begin
                pick       = mtag_t'((int'(last_q) + k) % num_masters);
                pick_valid = 1'b1;
            end
        end
    end

    assign win       = locked_q ? locked_idx_q : pick;
    assign s_arvalid = locked_q || pick_valid;
    assign s_hs      = s_arvalid && s_arready;

    always_comb begin
        for (int m = 0; m < num_masters; m++) begin
            grant[m]   = s_arvalid && (win == mtag_t'(m));
            req_pop[m] = grant[m] && s_arready;
        end
    end

    always_comb begin
        s_ar.sid   = {win, req[win].id};    // tag goes on top of the master id
        s_ar.addr  = req[win].addr;
        s_ar.len   = req[win].len;
        s_ar.size  = req[win].size;
        s_ar.burst = req[win].burst;
    end

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            last_q       <= mtag_t'(num_masters - 1);   // master 0 goes first
            locked_q     <= 1'b0;
            locked_idx_q <= '0;
        end else if (s_hs) begin
            last_q   <= win;
            locked_q <= 1'b0;
        end else if (s_arvalid) begin
            locked_q     <= 1'b1;
            locked_idx_q <= win;
        end
    end

    // one grant at most and only to a requesting master
    assert property (@(posedge axi_clk) disable iff (reset)
        $onehot0(grant) && (grant & ~req_valid) == '0);

    // round robin bound, counted in handshakes won by other masters
    for (genvar m = 0; m < num_masters; m++) begin : g_fair
        mtag_t skips;

        always_ff @(posedge axi_clk) begin
            if (reset || !req_valid[m] || req_pop[m])
                skips <= '0;
            else if (s_hs && skips != '1)
                skips <= skips + 1'b1;
        end

        assert property (@(posedge axi_clk) disable iff (reset) skips < num_masters);
    end

endmodule

// File: verilog/r_return_arbiter.sv
`timescale 1ns/1ps

module r_return_arbiter #(
    parameter int master_idx = 0
) (
    input  logic                                axi_clk,
    input  logic                                reset,
    input  axi_xbar_pkg::s_r_beat_t             s_r [axi_xbar_pkg::num_slaves],
    input  logic [axi_xbar_pkg::num_slaves-1:0] s_rvalid,
    output logic [axi_xbar_pkg::num_slaves-1:0] s_rready,
    output axi_xbar_pkg::r_beat_t               m_r,
    output logic                                m_rvalid,
    input  logic                                m_rready
);
    import axi_xbar_pkg::*;

    logic [num_slaves-1:0] hit;         // slave has a beat tagged for this master
    sidx_t                 last_q;      // slave of the last finished burst
    logic                  locked_q;
    sidx_t                 lock_idx_q;
    sidx_t                 pick;
    logic                  pick_valid;
    sidx_t                 sel;
    logic                  m_hs;

    always_comb begin
        for (int s = 0; s < num_slaves; s++) begin
            hit[s] = s_rvalid[s] && (s_r[s].sid[sid_w-1 -: mtag_w] == mtag_t'(master_idx));
        end
    end

    always_comb begin
        pick       = last_q;
        pick_valid = 1'b0;
        for (int k = num_slaves; k >= 1; k--) begin
            if (hit[(int'(last_q) + k) % num_slaves]) begin
                pick       = sidx_t'((int'(last_q) + k) % num_slaves);
                pick_valid = 1'b1;
            end
        end
    end

    assign sel      = locked_q ? lock_idx_q : pick;
    assign m_rvalid = locked_q ? hit[lock_idx_q] : pick_valid;
    assign m_hs     = m_rvalid && m_rready;

    always_comb begin
        m_r.id   = s_r[sel].sid[id_w-1:0];  // master tag stripped
        m_r.data = s_r[sel].data;
        m_r.resp = s_r[sel].resp;
        m_r.last = s_r[sel].last;
    end

    always_comb begin
        for (int s = 0; s < num_slaves; s++) begin
            s_rready[s] = m_rready && m_rvalid && (sel == sidx_t'(s));
        end
    end

    // lock taken as soon as a beat is offered, so m_r holds while the fifo is full
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            last_q     <= sidx_t'(num_slaves - 1);
            locked_q   <= 1'b0;
            lock_idx_q <= '0;
        end else if (m_rvalid) begin
            lock_idx_q <= sel;
            locked_q   <= !(m_hs && m_r.last);
            if (m_hs && m_r.last)
                last_q <= sel;                  // burst done, rotate
        end
    end

    // no interleaving of bursts from two slaves
    assert property (@(posedge axi_clk) disable iff (reset)
        locked_q && !(m_hs && m_r.last) |=> locked_q && $stable(lock_idx_q));

endmodule

// File: verilog/axi_xbar.sv
`timescale 1ns/1ps

module axi_xbar (
    input  logic                                 axi_clk,
    input  logic                                 reset,
    input  axi_xbar_pkg::ar_req_t                m_ar [axi_xbar_pkg::num_masters],
    input  logic [axi_xbar_pkg::num_masters-1:0] m_arvalid,
    output logic [axi_xbar_pkg::num_masters-1:0] m_arready,
    output axi_xbar_pkg::r_beat_t                m_r [axi_xbar_pkg::num_masters],
    output logic [axi_xbar_pkg::num_masters-1:0] m_rvalid,
    input  logic [axi_xbar_pkg::num_masters-1:0] m_rready,
    output axi_xbar_pkg::s_ar_req_t              s_ar [axi_xbar_pkg::num_slaves],
    output logic [axi_xbar_pkg::num_slaves-1:0]  s_arvalid,
    input  logic [axi_xbar_pkg::num_slaves-1:0]  s_arready,
    input  axi_xbar_pkg::s_r_beat_t              s_r [axi_xbar_pkg::num_slaves],
    input  logic [axi_xbar_pkg::num_slaves-1:0]  s_rvalid,
    output logic [axi_xbar_pkg::num_slaves-1:0]  s_rready
);
    import axi_xbar_pkg::*;

    ar_req_t                ar_head [num_masters];        // ar fifo outputs
    logic [num_masters-1:0] ar_head_valid;
    logic [num_masters-1:0] ar_pop;
    logic [num_masters-1:0] slv_req_valid [num_slaves];   // heads decoded per slave
    logic [num_masters-1:0] slv_pop [num_slaves];
    r_beat_t                r_push [num_masters];
    logic [num_masters-1:0] r_push_valid;
    logic [num_masters-1:0] r_push_ready;
    logic [num_slaves-1:0]  mst_rready [num_masters];

    always_comb begin
        for (int s = 0; s < num_slaves; s++) begin
            for (int m = 0; m < num_masters; m++) begin
                slv_req_valid[s][m] = ar_head_valid[m] &&
                    (ar_head[m].addr[sel_lsb +: sidx_w] == sidx_t'(s));
            end
        end
    end

    always_comb begin
        ar_pop = '0;
        for (int s = 0; s < num_slaves; s++)
            ar_pop = ar_pop | slv_pop[s];
    end

    // only the master named in the rid tag drives a slave's rready
    always_comb begin
        s_rready = '0;
        for (int m = 0; m < num_masters; m++)
            s_rready = s_rready | mst_rready[m];
    end

    for (genvar m = 0; m < num_masters; m++) begin : g_master
        axi_fifo_sync #(.width($bits(ar_req_t)), .aw(fifo_aw)) u_ar_fifo (
            .axi_clk  (axi_clk),
            .reset    (reset),
            .wr_valid (m_arvalid[m]),
            .wr_ready (m_arready[m]),
            .wr_data  (m_ar[m]),
            .rd_valid (ar_head_valid[m]),
            .rd_ready (ar_pop[m]),
            .rd_data  (ar_head[m])
        );

        r_return_arbiter #(.master_idx(m)) u_r_arb (
            .axi_clk  (axi_clk),
            .reset    (reset),
            .s_r      (s_r),
            .s_rvalid (s_rvalid),
            .s_rready (mst_rready[m]),
            .m_r      (r_push[m]),
            .m_rvalid (r_push_valid[m]),
            .m_rready (r_push_ready[m])
        );

        axi_fifo_sync #(.width($bits(r_beat_t)), .aw(fifo_aw)) u_r_fifo (
            .axi_clk  (axi_clk),
            .reset    (reset),
            .wr_valid (r_push_valid[m]),
            .wr_ready (r_push_ready[m]),
            .wr_data  (r_push[m]),
            .rd_valid (m_rvalid[m]),
            .rd_ready (m_rready[m]),
            .rd_data  (m_r[m])
        );

        // select 3 has no slave, such a head would never leave the fifo
        assert property (@(posedge axi_clk) disable iff (reset)
            ar_head_valid[m] |-> ar_head[m].addr[sel_lsb +: sidx_w] != sidx_t'(num_slaves));
    end

    for (genvar s = 0; s < num_slaves; s++) begin : g_slave
        ar_arbiter u_ar_arb (
            .axi_clk   (axi_clk),
            .reset     (reset),
            .req       (ar_head),
            .req_valid (slv_req_valid[s]),
            .req_pop   (slv_pop[s]),
            .s_ar      (s_ar[s]),
            .s_arvalid (s_arvalid[s]),
            .s_arready (s_arready[s])
        );
    end

endmodule

// File: bench/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model #(
    parameter int slave_idx = 0
) (
    input  logic                    axi_clk,
    input  logic                    reset,
    input  axi_xbar_pkg::s_ar_req_t s_ar,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output axi_xbar_pkg::s_r_beat_t s_r,
    output logic                    s_rvalid,
    input  logic                    s_rready
);
    import axi_xbar_pkg::*;

    s_ar_req_t pending [$];     // accepted reads, served in order
    s_ar_req_t ar_q;
    int        beat;            // beat number inside the head read
    int        seed;
    logic      ar_hs;
    logic      r_hs;
    logic      rst_q;

    initial begin
        seed      = 32'hf62c + 101 * (slave_idx + 1);
        s_arready = 1'b0;
        s_rvalid  = 1'b0;
        s_r       = '0;
        beat      = 0;
        forever begin
            // sampled mid cycle, the next edge completes the transfer
            @(negedge axi_clk);
            ar_hs = s_arvalid && s_arready;
            r_hs  = s_rvalid && s_rready;
            ar_q  = s_ar;
            rst_q = reset;
            @(posedge axi_clk);
            #1;
            if (rst_q) begin
                pending.delete();
                beat      = 0;
                s_arready = 1'b0;
                s_rvalid  = 1'b0;
            end else begin
                if (ar_hs)
                    pending.push_back(ar_q);
                if (r_hs) begin
                    if (s_r.last) begin
                        void'(pending.pop_front());
                        beat = 0;
                    end else begin
                        beat++;
                    end
                end
                // rvalid only drops after a transfer
                if (!s_rvalid || r_hs) begin
                    s_rvalid = pending.size() > 0 && ($random(seed) % 4 != 0);
                    if (s_rvalid) begin
                        s_r.sid  = pending[0].sid;
                        s_r.data = pending[0].addr + data_t'(4 * beat);
                        s_r.resp = resp_okay;
                        s_r.last = (beat == int'(pending[0].len));
                    end
                end
                s_arready = pending.size() < 4 && ($random(seed) % 3 != 0);   // random stalls
            end
        end
    end

endmodule

// File: bench/axi_xbar_tb.sv
`timescale 1ns/1ps

module axi_xbar_tb;
    import axi_xbar_pkg::*;

    localparam int reads_per_master = 24;
    localparam int fair_reads       = 2;    // two queued per master, a biased arbiter shows
    localparam int wait_limit       = 20000;
    localparam int num_ids          = 1 << id_w;

    logic                   axi_clk;
    logic                   reset;
    ar_req_t                m_ar [num_masters];
    logic [num_masters-1:0] m_arvalid;
    logic [num_masters-1:0] m_arready;
    r_beat_t                m_r [num_masters];
    logic [num_masters-1:0] m_rvalid;
    logic [num_masters-1:0] m_rready;
    s_ar_req_t              s_ar [num_slaves];
    logic [num_slaves-1:0]  s_arvalid;
    logic [num_slaves-1:0]  s_arready;
    s_r_beat_t              s_r [num_slaves];
    logic [num_slaves-1:0]  s_rvalid;
    logic [num_slaves-1:0]  s_rready;

    int    seed = 32'hf62c;
    logic  run;                 // random reads enabled
    logic  idle_chk;            // no traffic expected
    logic  fair_go;             // every master aims at slave 1 together
    int    fair_skips [num_masters];   // slave 1 handshakes won by others meanwhile
    int    fair_won [num_masters];     // slave 1 handshakes won since fair_go
    int    done_cnt [num_masters];
    int    outstanding [num_masters];
    logic  busy [num_masters][num_ids];
    logic  seen [num_masters][num_ids];   // request already reached its slave
    addr_t req_addr [num_masters][num_ids];
    len_t  req_len [num_masters][num_ids];
    int    beat_cnt [num_masters][num_ids];

    initial axi_clk = 1'b0;
    always #4 axi_clk = !axi_clk;

    axi_xbar uut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        abort_run($sformatf("ERR %s got %0h expected %0h", name, got, exp));
    endtask

    task automatic check_slave_ar(input int s, input s_ar_req_t req);
        int  m;
        id_t id;
        m  = int'(req.sid[sid_w-1 -: mtag_w]);
        id = req.sid[id_w-1:0];
        if (m >= num_masters || !busy[m][id] || seen[m][id])
            abort_run($sformatf("slave %0d got sid %0h that no master has pending", s, req.sid));
        assert (req.addr == req_addr[m][id])
            else value_error("s_ar.addr", req.addr, req_addr[m][id]);
        assert (req.len == req_len[m][id]) else value_error("s_ar.len", req.len, req_len[m][id]);
        assert (req.size == 3'd2) else value_error("s_ar.size", req.size, 3'd2);
        assert (req.burst == 2'b01) else value_error("s_ar.burst", req.burst, 2'b01);
        seen[m][id] = 1'b1;
        if (fair_go && s == 1) begin
            for (int k = 0; k < num_masters; k++) begin
                if (k == m) begin
                    fair_skips[k] = 0;
                    fair_won[k]++;
                end else if (fair_won[k] < fair_reads) begin
                    fair_skips[k]++;
                    assert (fair_skips[k] < num_masters)
                        else abort_run($sformatf("master %0d passed over %0d times on slave 1",
                                                 k, fair_skips[k]));
                end
            end
        end
    endtask

    task automatic check_beat(input int m, input r_beat_t rb);
        int    b;
        addr_t exp_data;
        b        = beat_cnt[m][rb.id];
        exp_data = req_addr[m][rb.id] + data_t'(4 * b);
        if (!busy[m][rb.id] || !seen[m][rb.id])
            abort_run($sformatf("master %0d got a beat for id %0h with no read", m, rb.id));
        assert (rb.data == exp_data) else value_error("m_r.data", rb.data, exp_data);
        assert (rb.resp == resp_okay) else value_error("m_r.resp", rb.resp, resp_okay);
        assert (rb.last == (b == int'(req_len[m][rb.id])))
            else value_error("m_r.last", rb.last, b == int'(req_len[m][rb.id]));
        beat_cnt[m][rb.id] = b + 1;
        if (rb.last) begin
            busy[m][rb.id] = 1'b0;
            outstanding[m]--;
            done_cnt[m]++;
        end
    endtask

    function automatic logic reads_done(input int n);
        for (int m = 0; m < num_masters; m++)
            if (done_cnt[m] < n || outstanding[m] != 0)
                return 1'b0;
        return 1'b1;
    endfunction

    assert property (@(posedge axi_clk) idle_chk |-> m_rvalid == '0)
        else value_error("m_rvalid", $sampled(m_rvalid), 0);
    assert property (@(posedge axi_clk) idle_chk |-> s_arvalid == '0)
        else value_error("s_arvalid", $sampled(s_arvalid), 0);

    always @(negedge axi_clk) begin
        for (int s = 0; s < num_slaves; s++)
            if (!reset && s_arvalid[s] && s_arready[s])
                check_slave_ar(s, s_ar[s]);
    end

    for (genvar s = 0; s < num_slaves; s++) begin : g_slave
        axi_slave_model #(.slave_idx(s)) u_slave (
            .axi_clk   (axi_clk),
            .reset     (reset),
            .s_ar      (s_ar[s]),
            .s_arvalid (s_arvalid[s]),
            .s_arready (s_arready[s]),
            .s_r       (s_r[s]),
            .s_rvalid  (s_rvalid[s]),
            .s_rready  (s_rready[s])
        );

        assert property (@(posedge axi_clk) disable iff (reset)
            s_arvalid[s] |-> s_ar[s].addr[sel_lsb +: 2] == 2'(s))
            else value_error("s_ar.addr select", $sampled(s_ar[s].addr[sel_lsb +: 2]), s);
    end

    for (genvar m = 0; m < num_masters; m++) begin : g_master
        ar_req_t ar;
        logic    arvalid;
        logic    rready;

        assign m_ar[m]      = ar;
        assign m_arvalid[m] = arvalid;
        assign m_rready[m]  = rready;

        // a stalled beat waits unchanged
        assert property (@(posedge axi_clk) disable iff (reset)
            m_rvalid[m] && !m_rready[m] |=> m_rvalid[m] && $stable(m_r[m]))
            else abort_run($sformatf("master %0d beat changed while rready was low", m));

        initial begin
            int   mseed;
            int   next_id;
            int   issued;
            int   sel;
            id_t  id;
            logic ar_hs;
            logic r_hs;
            mseed   = seed + 7 * m;
            next_id = 0;
            issued  = 0;
            ar      = '0;
            arvalid = 1'b0;
            rready  = 1'b0;
            forever begin
                @(negedge axi_clk);
                ar_hs = arvalid && m_arready[m];
                r_hs  = m_rvalid[m] && rready;
                if (r_hs && !reset)
                    check_beat(m, m_r[m]);
                @(posedge axi_clk);
                #1;
                if (ar_hs)
                    arvalid = 1'b0;
                if (!arvalid && outstanding[m] < 2 &&
                    ((run && issued < reads_per_master && $random(mseed) % 2 == 0) ||
                     (fair_go && issued < reads_per_master + fair_reads))) begin
                    sel     = fair_go ? 1 : $unsigned($random(mseed)) % num_slaves;
                    id      = id_t'(next_id % num_ids);    // ids cycle, two in flight at most
                    next_id++;
                    ar.id   = id;
                    ar.addr = $random(mseed);
                    ar.addr[31:30]         = 2'b00;
                    ar.addr[sel_lsb +: 2]  = 2'(sel);
                    ar.addr[1:0]           = 2'b00;
                    ar.len   = len_t'($unsigned($random(mseed)) % 8);
                    ar.size  = 3'd2;
                    ar.burst = 2'b01;
                    busy[m][id]     = 1'b1;
                    seen[m][id]     = 1'b0;
                    req_addr[m][id] = ar.addr;
                    req_len[m][id]  = ar.len;
                    beat_cnt[m][id] = 0;
                    outstanding[m]++;
                    issued++;
                    arvalid = 1'b1;
                end
                rready = ($random(mseed) % 3 != 0);
            end
        end
    end

    initial begin
        int cycles;
        reset    = 1'b1;
        run      = 1'b0;
        idle_chk = 1'b0;
        fair_go  = 1'b0;
        for (int m = 0; m < num_masters; m++) begin
            done_cnt[m]    = 0;
            outstanding[m] = 0;
            fair_skips[m]  = 0;
            fair_won[m]    = 0;
            for (int i = 0; i < num_ids; i++) begin
                busy[m][i] = 1'b0;
                seen[m][i] = 1'b0;
            end
        end
        repeat (3) @(posedge axi_clk);
        #1;
        reset    = 1'b0;
        idle_chk = 1'b1;
        repeat (10) @(posedge axi_clk);
        idle_chk = 1'b0;
        run      = 1'b1;
        cycles   = 0;
        while (!reads_done(reads_per_master)) begin
            @(posedge axi_clk);
            cycles++;
            if (cycles > wait_limit)
                abort_run("timeout while the random reads were still running");
        end
        run     = 1'b0;
        fair_go = 1'b1;
        cycles  = 0;
        while (!reads_done(reads_per_master + fair_reads)) begin
            @(posedge axi_clk);
            cycles++;
            if (cycles > wait_limit)
                abort_run("timeout while all masters were reading from slave 1");
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: axi_xbar.f
verilog/axi_xbar_pkg.sv
verilog/axi_fifo_sync.sv
verilog/ar_arbiter.sv
verilog/r_return_arbiter.sv
verilog/axi_xbar.sv
bench/axi_slave_model.sv
bench/axi_xbar_tb.sv
